//--- include/crop_settings.svh
`ifndef CROP_SETTINGS_SVH
`define CROP_SETTINGS_SVH

//////////////////////////////
// Pixel format
//////////////////////////////

// Bits per pixel on the stream
`define PIXEL_WIDTH 8

//////////////////////////////
// Image geometry
//////////////////////////////

// Column index and window width
`define IMG_WBITS 12

// Row index and window height
`define IMG_HBITS 12

`endif

//--- hw/crop_pkg.sv
`include "crop_settings.svh"

package crop_pkg;

	// One pixel per beat, flags ride along with the data
	typedef struct packed {
		logic [`PIXEL_WIDTH-1:0] data;
		logic                    sof;
		logic                    eol;
	} pixel_beat_t;

	// Crop rectangle in image coordinates
	typedef struct packed {
		logic [`IMG_WBITS-1:0] left;
		logic [`IMG_WBITS-1:0] width;
		logic [`IMG_HBITS-1:0] top;
		logic [`IMG_HBITS-1:0] height;
	} crop_window_t;

	// Line framing of the crop stage
	typedef enum logic [1:0] {
		LINE_IDLE   = 2'd0,
		LINE_GAP    = 2'd1,
		LINE_STREAM = 2'd2
	} line_state_e;

endpackage

//--- hw/window_tracker.sv
`include "crop_settings.svh"

module window_tracker import crop_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  frame_start,
	input  logic                  line_start,
	input  logic                  col_advance,
	input  logic [`IMG_WBITS-1:0] col_idx,
	input  logic [`IMG_HBITS-1:0] row_idx,
	input  crop_window_t          win,
	output logic                  keep,
	output logic                  is_sof,
	output logic                  is_eol
);

	crop_window_t win_q;

	// One extra bit so a window touching the image edge does not wrap
	logic [`IMG_WBITS:0] right_q;
	logic [`IMG_HBITS:0] bottom_q;
	logic                bounds_load;

	logic sof_pending;
	logic eol_pending;
	logic idx_live;

	logic [`IMG_WBITS:0] col_ext;
	logic [`IMG_WBITS:0] col_plus1;
	logic [`IMG_HBITS:0] row_ext;
	logic                col_hit;
	logic                row_hit;

	//////////////////////////////
	// Per-frame window
	//////////////////////////////

	// Window is frozen for the whole frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			win_q <= win;
		end else if (frame_start) begin
			win_q <= win;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bounds_load <= 1'b0;
		end else begin
			bounds_load <= frame_start;
		end
	end

	// Bounds follow one cycle behind the window register,
	// still ahead of the first held pixel of the frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			right_q  <= {1'b0, win.left} + {1'b0, win.width};
			bottom_q <= {1'b0, win.top} + {1'b0, win.height};
		end else if (bounds_load) begin
			right_q  <= {1'b0, win_q.left} + {1'b0, win_q.width};
			bottom_q <= {1'b0, win_q.top} + {1'b0, win_q.height};
		end
	end

	//////////////////////////////
	// Flag bookkeeping
	//////////////////////////////

	// Indices point into the current line once its first pixel is taken
	always_ff @(posedge clk) begin
		if (!resetn) begin
			idx_live <= 1'b0;
		end else if (line_start) begin
			idx_live <= 1'b0;
		end else if (col_advance) begin
			idx_live <= 1'b1;
		end
	end

	// One sof per frame and one eol per line at most
	always_ff @(posedge clk) begin
		if (!resetn) begin
			sof_pending <= 1'b0;
		end else if (frame_start) begin
			sof_pending <= 1'b1;
		end else if (col_advance && idx_live && is_sof) begin
			sof_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			eol_pending <= 1'b0;
		end else if (line_start) begin
			eol_pending <= 1'b1;
		end else if (col_advance && idx_live && is_eol) begin
			eol_pending <= 1'b0;
		end
	end

	//////////////////////////////
	// Position compare
	//////////////////////////////

	always_comb begin
		col_ext   = {1'b0, col_idx};
		row_ext   = {1'b0, row_idx};
		col_plus1 = col_ext + 1'b1;

		col_hit = (col_idx >= win_q.left) && (col_ext < right_q);
		row_hit = (row_idx >= win_q.top) && (row_ext < bottom_q);
		keep    = col_hit && row_hit;

		// Top-left corner of the window
		is_sof = keep && sof_pending && (col_idx == win_q.left) && (row_idx == win_q.top);
		// Rightmost kept column
		is_eol = keep && eol_pending && (col_plus1 == right_q);
	end

endmodule

//--- hw/window_crop.sv
`include "crop_settings.svh"

module window_crop import crop_pkg::*; (
	input  logic         clk,
	input  logic         resetn,

	input  pixel_beat_t  in_beat,
	input  logic         in_valid,
	output logic         in_ready,

	output pixel_beat_t  out_beat,
	output logic         out_valid,
	input  logic         out_ready,

	input  crop_window_t win
);

	line_state_e state;
	line_state_e state_next;

	// Single pixel holding register
	logic [`PIXEL_WIDTH-1:0] hold_data;
	logic                    hold_eol;
	logic                    hold_valid;
	logic                    hold_drain;
	logic                    in_take;

	// Position of the held pixel
	logic [`IMG_WBITS-1:0] col_idx;
	logic [`IMG_WBITS-1:0] col_next;
	logic [`IMG_HBITS-1:0] row_idx;

	logic frame_start;
	logic line_start;

	logic keep;
	logic is_sof;
	logic is_eol;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	assign line_start  = (state == LINE_GAP);
	assign frame_start = line_start && in_valid && in_beat.sof;

	// Dropped pixels leave at once, kept ones wait for the sink
	assign hold_drain = hold_valid && (!keep || out_ready);

	// Input closes once the eol pixel sits in the register
	assign in_ready = (state == LINE_STREAM) && (!hold_valid || (hold_drain && !hold_eol));
	assign in_take  = in_valid && in_ready;

	//////////////////////////////
	// Line FSM
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			LINE_IDLE: begin
				if (in_valid) begin
					state_next = LINE_GAP;
				end
			end
			LINE_GAP: begin
				state_next = LINE_STREAM;
			end
			LINE_STREAM: begin
				// Line ends when its last pixel leaves the register
				if (hold_valid && hold_eol && hold_drain) begin
					state_next = LINE_IDLE;
				end
			end
			default: begin
				state_next = LINE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= LINE_IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Column and row counters
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_idx  <= '0;
			col_next <= '0;
		end else if (line_start) begin
			col_next <= '0;
		end else if (in_take) begin
			col_idx  <= col_next;
			col_next <= col_next + 1'b1;
		end
	end

	// All ones after reset, so a stray first line without sof lands on row 0
	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_idx <= '1;
		end else if (line_start) begin
			row_idx <= frame_start ? '0 : row_idx + 1'b1;
		end
	end

	//////////////////////////////
	// Pixel register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			hold_valid <= 1'b0;
			hold_eol   <= 1'b0;
		end else if (in_take) begin
			hold_valid <= 1'b1;
			hold_eol   <= in_beat.eol;
		end else if (hold_drain) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_take) begin
			hold_data <= in_beat.data;
		end
	end

	window_tracker u_tracker (
		.clk         (clk),
		.resetn      (resetn),
		.frame_start (frame_start),
		.line_start  (line_start),
		.col_advance (in_take),
		.col_idx     (col_idx),
		.row_idx     (row_idx),
		.win         (win),
		.keep        (keep),
		.is_sof      (is_sof),
		.is_eol      (is_eol)
	);

	// Flags are regenerated for the cropped image
	assign out_valid = hold_valid && keep;
	assign out_beat  = '{data: hold_data, sof: is_sof, eol: is_eol};

endmodule

//--- hw/video_crop_top.sv
`include "crop_settings.svh"

module video_crop_top import crop_pkg::*; (
	input  logic                    clk,
	input  logic                    resetn,

	input  logic                    s_valid,
	input  logic [`PIXEL_WIDTH-1:0] s_data,
	input  logic                    s_sof,
	input  logic                    s_eol,
	output logic                    s_ready,

	output logic                    m_valid,
	output logic [`PIXEL_WIDTH-1:0] m_data,
	output logic                    m_sof,
	output logic                    m_eol,
	input  logic                    m_ready,

	input  logic [`IMG_WBITS-1:0]   win_left,
	input  logic [`IMG_HBITS-1:0]   win_top,
	input  logic [`IMG_WBITS-1:0]   win_width,
	input  logic [`IMG_HBITS-1:0]   win_height
);

	pixel_beat_t  in_beat;
	pixel_beat_t  out_beat;
	crop_window_t win;

	assign in_beat = '{data: s_data, sof: s_sof, eol: s_eol};
	assign win     = '{left: win_left, width: win_width, top: win_top, height: win_height};

	assign m_data = out_beat.data;
	assign m_sof  = out_beat.sof;
	assign m_eol  = out_beat.eol;

	window_crop u_crop (
		.clk       (clk),
		.resetn    (resetn),
		.in_beat   (in_beat),
		.in_valid  (s_valid),
		.in_ready  (s_ready),
		.out_beat  (out_beat),
		.out_valid (m_valid),
		.out_ready (m_ready),
		.win       (win)
	);

endmodule

//--- bench/video_crop_chk.sv
`include "crop_settings.svh"

module video_crop_chk import crop_pkg::*; (
	input logic                    clk,
	input logic                    resetn,
	input logic                    s_ready,
	input logic                    m_valid,
	input logic [`PIXEL_WIDTH-1:0] m_data,
	input logic                    m_sof,
	input logic                    m_eol,
	input logic                    m_ready,
	input line_state_e             line_state
);

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////
	// Reset state
	//////////////////////////////

	a_reset_quiet: assert property (@(posedge clk) !resetn |=> !m_valid)
		else $error("m_valid high in the cycle after reset");

	//////////////////////////////
	// Output handshake
	//////////////////////////////

	// A stalled beat holds still until taken
	a_out_stable: assert property (@(posedge clk) disable iff (!resetn)
		m_valid && !m_ready |=> m_valid && $stable({m_data, m_sof, m_eol}))
		else $error("stalled output beat changed");

	// Dead input cycle between lines, previous line fully gone
	a_gap_closed: assert property (@(posedge clk) disable iff (!resetn)
		line_state == LINE_GAP |-> !s_ready && !m_valid)
		else $error("s_ready or m_valid high during the line gap");

endmodule

bind video_crop_top video_crop_chk u_chk (
	.clk        (clk),
	.resetn     (resetn),
	.s_ready    (s_ready),
	.m_valid    (m_valid),
	.m_data     (m_data),
	.m_sof      (m_sof),
	.m_eol      (m_eol),
	.m_ready    (m_ready),
	.line_state (u_crop.state)
);

//--- bench/video_crop_tb.sv
`include "crop_settings.svh"

module video_crop_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                    clk;
	logic                    resetn;
	logic                    s_valid;
	logic [`PIXEL_WIDTH-1:0] s_data;
	logic                    s_sof;
	logic                    s_eol;
	logic                    s_ready;
	logic                    m_valid;
	logic [`PIXEL_WIDTH-1:0] m_data;
	logic                    m_sof;
	logic                    m_eol;
	logic                    m_ready;
	logic [`IMG_WBITS-1:0]   win_left;
	logic [`IMG_HBITS-1:0]   win_top;
	logic [`IMG_WBITS-1:0]   win_width;
	logic [`IMG_HBITS-1:0]   win_height;

	// One entry per test record
	int t_w[$];
	int t_h[$];
	int t_frames[$];
	int t_stall[$];
	int t_win1[$][4];
	int t_win2[$][4];
	int t_nexp[$];
	int t_pbase[$];
	int t_ebase[$];

	// Pixels and expected beats of all tests, packed as data, sof, eol
	int pix_q[$];
	int exp_q[$];

	int       err_count;
	int       fail_tests;
	int       limit_cycles;
	bit [7:0] lfsr_state;

	video_crop_top DUT (.*);

	always #5 clk = ~clk;

	////////////////////////////////
	// Helpers
	////////////////////////////////

	function automatic bit [7:0] lfsr_step(input bit [7:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 8'hb8;
		end
		return s >> 1;
	endfunction

	function automatic bit next_ready_bit();
		lfsr_state = lfsr_step(lfsr_state);
		return lfsr_state[0];
	endfunction

	// Skips comments that start with #
	task automatic read_value(input int fd, output int v);
		string tok;
		string rest;
		int    n;
		v = -1;
		forever begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1) begin
				return;
			end
			if (tok.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
			end else if (tok == "test") begin
				v = -2;
				return;
			end else if (tok == "end") begin
				return;
			end else begin
				n = $sscanf(tok, "%h", v);
				return;
			end
		end
	endtask

	task automatic load_tests();
		int fd;
		int v;
		int n;
		int hdr[13];
		fd = $fopen("bench/crop_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file bench/crop_input.txt");
			err_count++;
		end else begin
			read_value(fd, v);
			while (v == -2) begin
				for (int i = 0; i < 13; i++) begin
					read_value(fd, hdr[i]);
				end
				t_w.push_back(hdr[0]);
				t_h.push_back(hdr[1]);
				t_frames.push_back(hdr[2]);
				t_stall.push_back(hdr[3]);
				t_win1.push_back('{hdr[4], hdr[5], hdr[6], hdr[7]});
				t_win2.push_back('{hdr[8], hdr[9], hdr[10], hdr[11]});
				t_nexp.push_back(hdr[12]);
				t_pbase.push_back(pix_q.size());
				t_ebase.push_back(exp_q.size());
				n = hdr[0] * hdr[1] * hdr[2];
				for (int i = 0; i < n; i++) begin
					read_value(fd, v);
					pix_q.push_back(v);
				end
				for (int i = 0; i < hdr[12]; i++) begin
					read_value(fd, v);
					read_value(fd, hdr[0]);
					read_value(fd, hdr[1]);
					exp_q.push_back((v << 2) | (hdr[0] << 1) | hdr[1]);
				end
				limit_cycles += n * 4 + 200 + 40;
				read_value(fd, v);
			end
			$fclose(fd);
			if (t_w.size() == 0) begin
				$display("No test records found in bench/crop_input.txt");
				err_count++;
			end
		end
	endtask

	task automatic set_window(input int w[4]);
		win_left   = `IMG_WBITS'(w[0]);
		win_top    = `IMG_HBITS'(w[1]);
		win_width  = `IMG_WBITS'(w[2]);
		win_height = `IMG_HBITS'(w[3]);
	endtask

	task automatic reset_dut();
		@(negedge clk);
		resetn  = 1'b0;
		s_valid = 1'b0;
		s_data  = '0;
		s_sof   = 1'b0;
		s_eol   = 1'b0;
		m_ready = 1'b0;
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		#1;
		assert (!m_valid && !s_ready) else begin
			$display("Handshake outputs not low after reset at %0t", $time);
			err_count++;
		end
	endtask

	task automatic compare_beat(input int word);
		logic [`PIXEL_WIDTH-1:0] exp_data;
		logic                    exp_sof;
		logic                    exp_eol;
		exp_data = word[`PIXEL_WIDTH+1:2];
		exp_sof  = word[1];
		exp_eol  = word[0];
		assert (m_data == exp_data) else begin
			$display("mismatch at %0t: m_data got %h expected %h", $time, m_data, exp_data);
			err_count++;
		end
		assert (m_sof == exp_sof) else begin
			$display("mismatch at %0t: m_sof got %b expected %b", $time, m_sof, exp_sof);
			err_count++;
		end
		assert (m_eol == exp_eol) else begin
			$display("mismatch at %0t: m_eol got %b expected %b", $time, m_eol, exp_eol);
			err_count++;
		end
	endtask

	////////////////////////////////
	// One test record
	////////////////////////////////

	task automatic run_test(input int t);
		int w;
		int npix;
		int nexp;
		int src_idx;
		int exp_idx;
		int cycles;
		int idle;
		int errs_before;
		bit src_fire;
		w           = t_w[t];
		npix        = t_w[t] * t_h[t] * t_frames[t];
		nexp        = t_nexp[t];
		errs_before = err_count;
		set_window(t_win1[t]);
		reset_dut();
		src_idx  = 0;
		exp_idx  = 0;
		cycles   = 0;
		idle     = 0;
		src_fire = 1'b0;
		while (idle < 20 && cycles < npix * 4 + 200) begin
			@(negedge clk);
			if (src_fire) begin
				src_idx++;
			end
			// New window once the first line is in
			if (src_idx >= w) begin
				set_window(t_win2[t]);
			end
			m_ready = t_stall[t] ? next_ready_bit() : 1'b1;
			if (src_idx < npix) begin
				s_valid = 1'b1;
				s_data  = `PIXEL_WIDTH'(pix_q[t_pbase[t] + src_idx]);
				s_sof   = (src_idx % (w * t_h[t])) == 0;
				s_eol   = (src_idx % w) == w - 1;
			end else begin
				s_valid = 1'b0;
				s_sof   = 1'b0;
				s_eol   = 1'b0;
			end
			#1;
			src_fire = s_valid && s_ready;
			if (m_valid && m_ready) begin
				if (exp_idx >= nexp) begin
					$display("Extra output beat with data %h at %0t", m_data, $time);
					err_count++;
				end else begin
					compare_beat(exp_q[t_ebase[t] + exp_idx]);
				end
				exp_idx++;
			end
			cycles++;
			if (src_idx == npix && exp_idx >= nexp) begin
				idle++;
			end
		end
		if (src_idx < npix) begin
			$display("Input stalled with %0d of %0d pixels not accepted", npix - src_idx, npix);
			err_count++;
		end
		if (exp_idx < nexp) begin
			$display("Output ended with %0d of %0d beats missing", nexp - exp_idx, nexp);
			err_count++;
		end
		if (err_count != errs_before) begin
			fail_tests++;
		end
		$display("test %0d: %0d pixels in, %0d beats out, %0d errors", t, npix, exp_idx,
			err_count - errs_before);
	endtask

	initial begin
		clk          = 1'b0;
		resetn       = 1'b0;
		s_valid      = 1'b0;
		s_data       = '0;
		s_sof        = 1'b0;
		s_eol        = 1'b0;
		m_ready      = 1'b0;
		win_left     = '0;
		win_top      = '0;
		win_width    = '0;
		win_height   = '0;
		err_count    = 0;
		fail_tests   = 0;
		limit_cycles = 0;
		lfsr_state   = 8'd8;
		load_tests();
		for (int t = 0; t < t_w.size(); t++) begin
			run_test(t);
		end
		$display("%0d tests, %0d failed, %0d errors", t_w.size(), fail_tests, err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- bench/crop_input.txt
# test W H frames stall | left top width height | left2 top2 width2 height2 | beats
# then the pixels in raster order, then one "data sof eol" triple per output beat
# all numbers hex

# full-frame window
test 4 3 1 0  0 0 4 3  0 0 4 3  c
00 01 02 03
10 11 12 13
20 21 22 23
00 1 0  01 0 0  02 0 0  03 0 1
10 0 0  11 0 0  12 0 0  13 0 1
20 0 0  21 0 0  22 0 0  23 0 1

# interior crop
test 6 5 1 0  1 1 3 2  1 1 3 2  6
00 01 02 03 04 05
10 11 12 13 14 15
20 21 22 23 24 25
30 31 32 33 34 35
40 41 42 43 44 45
11 1 0  12 0 0  13 0 1
21 0 0  22 0 0  23 0 1

# interior crop with random stalls on m_ready
test 6 5 1 1  1 1 3 2  1 1 3 2  6
00 01 02 03 04 05
10 11 12 13 14 15
20 21 22 23 24 25
30 31 32 33 34 35
40 41 42 43 44 45
11 1 0  12 0 0  13 0 1
21 0 0  22 0 0  23 0 1

# window changes after the first line, second frame picks it up
test 4 3 2 0  0 0 2 3  1 1 2 1  8
00 01 02 03
10 11 12 13
20 21 22 23
80 81 82 83
90 91 92 93
a0 a1 a2 a3
00 1 0  01 0 1
10 0 0  11 0 1
20 0 0  21 0 1
91 1 0  92 0 1

# single pixel window, two frames
test 3 3 2 0  1 1 1 1  1 1 1 1  2
00 01 02
10 11 12
20 21 22
80 81 82
90 91 92
a0 a1 a2
11 1 1
91 1 1
end

//--- video_crop_top.f
+incdir+include
hw/crop_pkg.sv
hw/window_tracker.sv
hw/window_crop.sv
hw/video_crop_top.sv
bench/video_crop_chk.sv
bench/video_crop_tb.sv

//--- Bender.yml
package:
  name: video_crop

sources:
  - include_dirs:
      - include
    files:
      - hw/crop_pkg.sv
      - hw/window_tracker.sv
      - hw/window_crop.sv
      - hw/video_crop_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/video_crop_chk.sv
      - bench/video_crop_tb.sv
